/* pcs_stripe_top.f */
hw/pcs_stripe_pkg.sv
hw/stripe_feed.sv
hw/lane_scrambler.sv
hw/stripe_collect.sv
hw/pcs_stripe_top.sv
bench/pcs_stripe_assert.sv
bench/tb_pcs_stripe.sv

/* Makefile */
# Verilator build and run for the stripe scrambler testbench
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_pcs_stripe
FILELIST   ?= pcs_stripe_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_pcs_stripe.sv */
// Testbench for the multi-lane 64b/66b transmit scrambler
// Random stripes are checked against a serial scrambler model

module tb_pcs_stripe;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_LANES = 4;
    // Polynomial x^58 + x^39 + 1 as seen by the serial model
    localparam int HIST_LEN  = 58;
    localparam int TAP_DELAY = 39;

    // Test lengths in stripes
    localparam int N_FIRST = 1;
    localparam int N_B2B   = 200;
    localparam int N_GAP   = 300;
    localparam int MAX_GAP = 3;
    localparam int N_BYP   = 40;
    localparam int N_ERR   = 50;
    localparam int N_BURST = 70;
    localparam int TIMEOUT_CYCLES = N_FIRST + N_B2B + N_GAP * (MAX_GAP + 1) +
                                    2 * N_BYP + N_ERR + N_BURST + 500;

    // Header modes for the stimulus
    localparam int HDR_VALID  = 0;
    localparam int HDR_RANDOM = 1;
    localparam int HDR_BAD    = 2;

    typedef pcs_stripe_pkg::lane_block_t [NUM_LANES-1:0] stripe_t;

    logic                     clk_156;
    logic                     async_reset_n;
    logic                     in_valid_i;
    stripe_t                  in_blocks_i;
    logic                     bypass_scram_i;
    logic                     out_valid_o;
    stripe_t                  out_blocks_o;
    pcs_stripe_pkg::seq_t     seq_o;
    pcs_stripe_pkg::err_cnt_t hdr_err_cnt_o;

    logic [31:0]         rng_state;
    logic [HIST_LEN-1:0] model_hist;
    stripe_t             exp_q[$];
    logic [6:0]          exp_seq_q[$];
    logic [6:0]          send_seq;
    int                  model_errs;
    int                  error_count;
    int                  check_count;
    int                  cycle_cnt;
    int                  out_cnt;
    string               test_name;

    pcs_stripe_top #(
        .NUM_LANES (NUM_LANES)
    ) u_pcs_stripe_top (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .in_valid_i     (in_valid_i),
        .in_blocks_i    (in_blocks_i),
        .bypass_scram_i (bypass_scram_i),
        .out_valid_o    (out_valid_o),
        .out_blocks_o   (out_blocks_o),
        .seq_o          (seq_o),
        .hdr_err_cnt_o  (hdr_err_cnt_o)
    );

    initial begin
        clk_156 = 1'b0;
        forever #5 clk_156 = ~clk_156;
    end

    //////////////////////////////////////////////////////////////////////
    // Random numbers and the reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // One bit at a time; model_hist[0] is the oldest bit
    function automatic pcs_stripe_pkg::block_t model_scramble(
        input pcs_stripe_pkg::block_t din,
        input logic                   byp
    );
        pcs_stripe_pkg::block_t dout;
        logic                   bit_out;
        for (int j = 0; j < 64; j++) begin
            if (byp) begin
                bit_out = din[j];
            end else begin
                bit_out = din[j] ^ model_hist[HIST_LEN-TAP_DELAY] ^ model_hist[0];
            end
            dout[j]    = bit_out;
            model_hist = {bit_out, model_hist[HIST_LEN-1:1]};
        end
        return dout;
    endfunction

    task automatic check_value(input string name, input logic [65:0] expected,
                               input logic [65:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic send_stripe(input int hdr_mode);
        stripe_t     blocks;
        stripe_t     expected;
        logic [31:0] r;
        @(posedge clk_156);
        #1;
        for (int i = 0; i < NUM_LANES; i++) begin
            r = next_rand();
            case (hdr_mode)
                HDR_VALID:  blocks[i].hdr = r[0] ? 2'b01 : 2'b10;
                HDR_RANDOM: blocks[i].hdr = r[1:0];
                default:    blocks[i].hdr = r[0] ? 2'b00 : 2'b11;
            endcase
            blocks[i].payload = {next_rand(), next_rand()};
            if (blocks[i].hdr != 2'b01 && blocks[i].hdr != 2'b10) begin
                model_errs++;
            end
            expected[i].hdr     = blocks[i].hdr;
            expected[i].payload = model_scramble(blocks[i].payload, bypass_scram_i);
        end
        // Count sticks at 255
        if (model_errs > 255) begin
            model_errs = 255;
        end
        exp_q.push_back(expected);
        exp_seq_q.push_back(send_seq);
        send_seq    = send_seq + 7'd1;
        in_valid_i  = 1'b1;
        in_blocks_i = blocks;
    endtask

    task automatic idle_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk_156);
            #1;
            in_valid_i = 1'b0;
        end
    endtask

    // Wait until every stripe sent has come out
    task automatic drain();
        idle_cycles(1);
        while (exp_q.size() != 0) begin
            @(posedge clk_156);
        end
        idle_cycles(2);
    endtask

    task automatic set_bypass(input logic value);
        @(posedge clk_156);
        #1;
        bypass_scram_i = value;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk_156) begin
        stripe_t expected;
        if (async_reset_n && out_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: out_valid_o went high with no stripe pending (%s)", test_name);
                error_count++;
            end else begin
                expected = exp_q.pop_front();
                for (int i = 0; i < NUM_LANES; i++) begin
                    check_value($sformatf("%s out %0d lane %0d", test_name, out_cnt, i),
                                66'(expected[i]), 66'(out_blocks_o[i]));
                end
                check_value($sformatf("%s out %0d seq", test_name, out_cnt),
                            66'(exp_seq_q.pop_front()), 66'(seq_o));
                out_cnt++;
            end
        end
    end

    always @(posedge clk_156) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int gap;
        rng_state      = 32'h90fc;
        model_hist     = pcs_stripe_pkg::HIST_RESET;
        send_seq       = '0;
        model_errs     = 0;
        error_count    = 0;
        check_count    = 0;
        out_cnt        = 0;
        test_name      = "reset";
        async_reset_n  = 1'b0;
        in_valid_i     = 1'b0;
        in_blocks_i    = '0;
        bypass_scram_i = 1'b0;
        repeat (2) @(posedge clk_156);
        #1;
        async_reset_n = 1'b1;

        check_value("reset out_valid_o", 66'(0), 66'(out_valid_o));
        check_value("reset seq_o", 66'(0), 66'(seq_o));
        check_value("reset hdr_err_cnt_o", 66'(0), 66'(hdr_err_cnt_o));

        test_name = "first stripe";
        repeat (N_FIRST) send_stripe(HDR_VALID);
        drain();

        test_name = "back to back";
        repeat (N_B2B) send_stripe(HDR_VALID);
        drain();

        // Also carries seq_o across several wraps
        test_name = "idle gaps";
        for (int n = 0; n < N_GAP; n++) begin
            send_stripe(HDR_VALID);
            gap = int'(next_rand() & 32'h3);
            idle_cycles(gap);
        end
        drain();

        test_name = "bypass";
        set_bypass(1'b1);
        repeat (N_BYP) send_stripe(HDR_VALID);
        drain();
        set_bypass(1'b0);
        test_name = "after bypass";
        repeat (N_BYP) send_stripe(HDR_VALID);
        drain();
        check_value("valid headers count", 66'(0), 66'(hdr_err_cnt_o));

        test_name = "random headers";
        repeat (N_ERR) send_stripe(HDR_RANDOM);
        drain();
        check_value("random headers count", 66'(model_errs), 66'(hdr_err_cnt_o));

        test_name = "bad header burst";
        repeat (N_BURST) send_stripe(HDR_BAD);
        drain();
        check_value("bad header burst count", 66'(255), 66'(hdr_err_cnt_o));

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* bench/pcs_stripe_assert.sv */
// Timing assertions for the stripe scrambler top level
// Latency, reset, sequence step and header pass-through

module pcs_stripe_assert #(
    parameter int NUM_LANES = 4
) (
    input logic                                        clk_156,
    input logic                                        async_reset_n,
    input logic                                        in_valid_i,
    input pcs_stripe_pkg::lane_block_t [NUM_LANES-1:0] in_blocks_i,
    input logic                                        out_valid_o,
    input pcs_stripe_pkg::lane_block_t [NUM_LANES-1:0] out_blocks_o,
    input pcs_stripe_pkg::seq_t                        seq_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [2*NUM_LANES-1:0] in_hdrs;
    logic [2*NUM_LANES-1:0] out_hdrs;
    pcs_stripe_pkg::seq_t   last_seq;
    logic                   have_prev;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            in_hdrs[2*i +: 2]  = in_blocks_i[i].hdr;
            out_hdrs[2*i +: 2] = out_blocks_o[i].hdr;
        end
    end

    // Seq number of the previous output stripe
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            have_prev <= 1'b0;
            last_seq  <= '0;
        end else if (out_valid_o) begin
            have_prev <= 1'b1;
            last_seq  <= seq_o;
        end
    end

    a_latency : assert property (@(posedge clk_156) disable iff (!async_reset_n)
        out_valid_o == $past(in_valid_i, 2))
        else $error("out_valid_o does not follow in_valid_i by 2 cycles");

    a_reset_low : assert property (@(posedge clk_156)
        !async_reset_n |-> !out_valid_o)
        else $error("out_valid_o high during reset");

    a_seq_step : assert property (@(posedge clk_156) disable iff (!async_reset_n)
        (out_valid_o && have_prev) |-> (seq_o == last_seq + 7'd1))
        else $error("seq_o did not step by one");

    a_hdr_pass : assert property (@(posedge clk_156) disable iff (!async_reset_n)
        out_valid_o |-> (out_hdrs == $past(in_hdrs, 2)))
        else $error("output headers differ from the input headers");

endmodule

bind pcs_stripe_top pcs_stripe_assert #(
    .NUM_LANES (NUM_LANES)
) u_pcs_stripe_assert (
    .clk_156       (clk_156),
    .async_reset_n (async_reset_n),
    .in_valid_i    (in_valid_i),
    .in_blocks_i   (in_blocks_i),
    .out_valid_o   (out_valid_o),
    .out_blocks_o  (out_blocks_o),
    .seq_o         (seq_o)
);

/* hw/pcs_stripe_top.sv */
// Transmit scrambling core for a multi-lane 64b/66b PCS
// Input register, chained lane scramblers, output register

module pcs_stripe_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                                        clk_156,
    input  logic                                        async_reset_n,
    input  logic                                        in_valid_i,
    input  pcs_stripe_pkg::lane_block_t [NUM_LANES-1:0] in_blocks_i,
    input  logic                                        bypass_scram_i,
    output logic                                        out_valid_o,
    output pcs_stripe_pkg::lane_block_t [NUM_LANES-1:0] out_blocks_o,
    output pcs_stripe_pkg::seq_t                        seq_o,
    output pcs_stripe_pkg::err_cnt_t                    hdr_err_cnt_o
);

    localparam int BLK_W = $bits(pcs_stripe_pkg::block_t);
    localparam int LEN   = pcs_stripe_pkg::SCR_LEN;

    logic                                        feed_valid;
    pcs_stripe_pkg::lane_block_t [NUM_LANES-1:0] feed_blocks;
    pcs_stripe_pkg::lane_block_t [NUM_LANES-1:0] scr_blocks;
    pcs_stripe_pkg::scr_hist_t                   hist_q;
    pcs_stripe_pkg::scr_hist_t                   lane_hist [NUM_LANES];

    stripe_feed #(
        .NUM_LANES (NUM_LANES)
    ) u_stripe_feed (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .in_valid_i    (in_valid_i),
        .in_blocks_i   (in_blocks_i),
        .feed_valid_o  (feed_valid),
        .feed_blocks_o (feed_blocks),
        .hdr_err_cnt_o (hdr_err_cnt_o)
    );

    ////////////////////////////////////////////////////////////////////
    // Lane chain
    ////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        // Lane 0 resumes from the previous stripe, the rest from their neighbour
        if (i == 0) begin : g_first
            assign lane_hist[i] = hist_q;
        end else begin : g_next
            assign lane_hist[i] = scr_blocks[i-1].payload[BLK_W-1 -: LEN];
        end

        lane_scrambler u_lane_scrambler (
            .blk_i    (feed_blocks[i]),
            .hist_i   (lane_hist[i]),
            .bypass_i (bypass_scram_i),
            .blk_o    (scr_blocks[i])
        );
    end

    stripe_collect #(
        .NUM_LANES (NUM_LANES)
    ) u_stripe_collect (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .scr_valid_i   (feed_valid),
        .scr_blocks_i  (scr_blocks),
        .hist_o        (hist_q),
        .out_valid_o   (out_valid_o),
        .out_blocks_o  (out_blocks_o),
        .seq_o         (seq_o)
    );

endmodule

/* hw/stripe_collect.sv */
// Output register stage for the scrambled stripe
// Keeps the history fed back to lane 0 and numbers each stripe

module stripe_collect #(
    parameter int NUM_LANES = 4
) (
    input  logic                                        clk_156,
    input  logic                                        async_reset_n,
    input  logic                                        scr_valid_i,
    input  pcs_stripe_pkg::lane_block_t [NUM_LANES-1:0] scr_blocks_i,
    output pcs_stripe_pkg::scr_hist_t                   hist_o,
    output logic                                        out_valid_o,
    output pcs_stripe_pkg::lane_block_t [NUM_LANES-1:0] out_blocks_o,
    output pcs_stripe_pkg::seq_t                        seq_o
);

    localparam int BLK_W = $bits(pcs_stripe_pkg::block_t);
    localparam int LEN   = pcs_stripe_pkg::SCR_LEN;

    logic                      out_valid_q;
    pcs_stripe_pkg::scr_hist_t hist_q;
    // Number shown with the current output stripe
    pcs_stripe_pkg::seq_t      seq_q;
    // Number the next stripe will carry
    pcs_stripe_pkg::seq_t      seq_nxt_q;

    ////////////////////////////////////////////////////////////////////
    // Control and history
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            out_valid_q <= 1'b0;
            hist_q      <= pcs_stripe_pkg::HIST_RESET;
            seq_q       <= '0;
            seq_nxt_q   <= '0;
        end else begin
            out_valid_q <= scr_valid_i;
            if (scr_valid_i) begin
                // Newest 58 bits of the last lane carry over to lane 0
                hist_q    <= scr_blocks_i[NUM_LANES-1].payload[BLK_W-1 -: LEN];
                seq_q     <= seq_nxt_q;
                // Wraps from 127 to 0 on its own
                seq_nxt_q <= seq_nxt_q + 7'd1;
            end
        end
    end

    // Stripe payload register
    always_ff @(posedge clk_156) begin
        if (scr_valid_i) begin
            out_blocks_o <= scr_blocks_i;
        end
    end

    assign hist_o      = hist_q;
    assign out_valid_o = out_valid_q;
    assign seq_o       = seq_q;

endmodule

/* hw/lane_scrambler.sv */
// Combinational x^58 + x^39 + 1 scrambler for the payload of one lane
// Header is passed as is; bypass selects the raw payload

module lane_scrambler (
    input  pcs_stripe_pkg::lane_block_t blk_i,
    input  pcs_stripe_pkg::scr_hist_t   hist_i,
    input  logic                        bypass_i,
    output pcs_stripe_pkg::lane_block_t blk_o
);

    localparam int BLK_W = $bits(pcs_stripe_pkg::block_t);
    localparam int LEN   = pcs_stripe_pkg::SCR_LEN;
    localparam int TAP   = pcs_stripe_pkg::SCR_TAP;

    pcs_stripe_pkg::block_t scr_payload;

    ////////////////////////////////////////////////////////////////////
    // Serial scrambler unrolled over the block
    ////////////////////////////////////////////////////////////////////

    // seq holds the history, oldest bit at 0, then the output bits.
    // Output bit j sits at seq[LEN+j], so its taps are LEN-TAP and 0 above j
    always_comb begin : scramble
        logic [LEN+BLK_W-1:0] seq;

        seq            = '0;
        seq[LEN-1:0]   = hist_i;
        for (int j = 0; j < BLK_W; j++) begin
            seq[LEN+j] = blk_i.payload[j] ^ seq[j+LEN-TAP] ^ seq[j];
        end
        scr_payload = seq[LEN+BLK_W-1:LEN];
    end

    // Sync header is never scrambled
    assign blk_o.hdr     = blk_i.hdr;
    assign blk_o.payload = bypass_i ? blk_i.payload : scr_payload;

endmodule

/* hw/stripe_feed.sv */
// Input register stage for one stripe of lane blocks
// Also counts blocks with an invalid sync header, saturating

module stripe_feed #(
    parameter int NUM_LANES = 4
) (
    input  logic                                        clk_156,
    input  logic                                        async_reset_n,
    input  logic                                        in_valid_i,
    input  pcs_stripe_pkg::lane_block_t [NUM_LANES-1:0] in_blocks_i,
    output logic                                        feed_valid_o,
    output pcs_stripe_pkg::lane_block_t [NUM_LANES-1:0] feed_blocks_o,
    output pcs_stripe_pkg::err_cnt_t                    hdr_err_cnt_o
);

    localparam int CNT_W = $clog2(NUM_LANES + 1);
    localparam int ERR_W = $bits(pcs_stripe_pkg::err_cnt_t);

    logic                     feed_valid_q;
    pcs_stripe_pkg::err_cnt_t err_cnt_q;
    logic [CNT_W-1:0]         bad_cnt;
    logic [ERR_W:0]           err_sum;

    // Number of bad headers in the incoming stripe
    always_comb begin
        bad_cnt = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if ((in_blocks_i[i].hdr != pcs_stripe_pkg::SYNC_DATA) &&
                (in_blocks_i[i].hdr != pcs_stripe_pkg::SYNC_CTRL)) begin
                bad_cnt = bad_cnt + CNT_W'(1);
            end
        end
    end

    // One spare bit catches the overflow
    assign err_sum = {1'b0, err_cnt_q} + (ERR_W + 1)'(bad_cnt);

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            feed_valid_q <= 1'b0;
            err_cnt_q    <= '0;
        end else begin
            feed_valid_q <= in_valid_i;
            if (in_valid_i) begin
                // Stick at all ones
                err_cnt_q <= err_sum[ERR_W] ? '1 : err_sum[ERR_W-1:0];
            end
        end
    end

    // Bad blocks pass through untouched
    always_ff @(posedge clk_156) begin
        if (in_valid_i) begin
            feed_blocks_o <= in_blocks_i;
        end
    end

    assign feed_valid_o  = feed_valid_q;
    assign hdr_err_cnt_o = err_cnt_q;

endmodule

/* hw/pcs_stripe_pkg.sv */
// Shared types and constants for the four-lane 64b/66b transmit scrambler
// Block, header, history and counter widths live here

package pcs_stripe_pkg;

    ////////////////////////////////////////////////////////////////////
    // Scrambler polynomial x^58 + x^39 + 1
    ////////////////////////////////////////////////////////////////////

    // Delay of the inner tap in bits
    localparam int SCR_TAP = 39;
    // Length of the scrambler history
    localparam int SCR_LEN = 58;

    ////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////

    // One 64-bit block payload
    typedef logic [63:0] block_t;

    // 66b sync header
    typedef logic [1:0] sync_hdr_t;

    // Scrambler history, bit 57 is the newest scrambled bit
    typedef logic [SCR_LEN-1:0] scr_hist_t;

    // Stripe sequence number on the output
    typedef logic [6:0] seq_t;

    // Count of blocks seen with a bad sync header
    typedef logic [7:0] err_cnt_t;

    // Full 66-bit block, header in the upper two bits
    typedef struct packed {
        sync_hdr_t hdr;
        block_t    payload;
    } lane_block_t;

    // Valid sync header codes
    localparam sync_hdr_t SYNC_DATA = 2'b01;
    localparam sync_hdr_t SYNC_CTRL = 2'b10;

    // History seen by lane 0 right after reset
    localparam scr_hist_t HIST_RESET = 58'd3;

endpackage
